// ==== compile.f ====
src/addr_map_pkg.sv
src/layer_sequencer.sv
src/reorder_counter.sv
src/reorder_addr_gen.sv
src/beat_delay.sv
src/ddr_ins_packer.sv
src/addr_map_top.sv
bench/tb_clock_gen.sv
bench/addr_map_tb.sv

// ==== bench/addr_map_tb.sv ====
`timescale 1ns/1ps

module addr_map_tb;

    import addr_map_pkg::*;

    localparam int LANE_W     = 32;
    localparam int LANES      = 16;
    localparam int DATA_W     = LANE_W * LANES;
    localparam int INS_W      = 1 + DATA_W + ADDR_W + BL_W;
    localparam int K_PW2DW    = 0;
    localparam int K_PW2PW    = 1;
    localparam int K_AVG      = 2;
    localparam int STIM_LIMIT = 4000;

    logic              clk_calc;
    logic              rst_n;
    logic [DATA_W-1:0] data_in_i;
    logic              data_in_vld_i;
    logic              ddr_wr_ins_vld_o;
    logic [INS_W-1:0]  ddr_wr_ins_o;
    logic              last_slice_vld_o;
    logic              net_all_finish_o;

    // reference copy of the layer table
    int kind_t [6] = '{K_PW2DW, K_PW2PW, K_PW2DW, K_PW2PW, K_AVG, K_PW2PW};
    int pic_t  [6] = '{8, 8, 4, 4, 1, 1};
    int grp_t  [6] = '{2, 2, 1, 2, 2, 1};
    int base_t [6] = '{1000000, 1000128, 1000256, 1000272, 1000304, 1000306};

    int               m_layer, m_col, m_row, m_chan, m_passes;
    logic             m_end;
    logic             m_slice;
    logic             exp_vld   [3];
    logic [INS_W-1:0] exp_ins   [3];
    logic             exp_slice [3];
    logic             exp_fin   [3];
    int               err [5];
    string            names [5] = '{"reset_idle", "addr_data", "burst_layer_end",
                                    "last_slice", "net_finish"};
    int               n_idle, n_ins, n_bl32, n_bl1, n_lend, n_slice, n_fin_exp, n_fin_obs;
    int               cycles, extra, total_err, n_ok;
    bit               timed_out;

    tb_clock_gen #(.PERIOD_NS(10.0), .RST_CYCLES(3)) u_clk (
        .clk_o   (clk_calc),
        .rst_n_o (rst_n)
    );

    addr_map_top #(.LANE_W(LANE_W), .LANES(LANES)) dut0 (
        .clk_calc         (clk_calc),
        .rst_n            (rst_n),
        .data_in_i        (data_in_i),
        .data_in_vld_i    (data_in_vld_i),
        .ddr_wr_ins_vld_o (ddr_wr_ins_vld_o),
        .ddr_wr_ins_o     (ddr_wr_ins_o),
        .last_slice_vld_o (last_slice_vld_o),
        .net_all_finish_o (net_all_finish_o)
    );

    function automatic logic [ADDR_W-1:0] ref_addr(input int lyr, input int c, input int r,
                                                   input int g);
        int p;
        p = pic_t[lyr];
        if (kind_t[lyr] == K_PW2DW) begin
            return ADDR_W'(base_t[lyr] + g * p * p + r * p + c);
        end else if (kind_t[lyr] == K_PW2PW) begin
            return ADDR_W'(base_t[lyr] + (r * p + c) * grp_t[lyr] + g);
        end
        return ADDR_W'(base_t[lyr] + g);
    endfunction

    function automatic logic [DATA_W-1:0] random_beat();
        logic [DATA_W-1:0] v;
        v = '0;
        repeat ((DATA_W + 31) / 32) v = (v << 32) | DATA_W'($urandom);
        return v;
    endfunction

    task automatic report_mismatch(input int t, input string what, input logic [1023:0] exp_v,
                                   input logic [1023:0] act_v);
        err[t]++;
        $display("Fail %s %s expected %0h actual %0h", names[t], what, exp_v, act_v);
    endtask

    task automatic not_reached(input int t, input string what);
        err[t]++;
        $display("%s: stimulus never reached the check, %s", names[t], what);
    endtask

    // ------------------------------------------------------------------
    // reference model queues each expected instruction for three edges
    // ------------------------------------------------------------------
    assign m_end   = m_col == pic_t[m_layer] - 1 && m_row == pic_t[m_layer] - 1
                     && m_chan == grp_t[m_layer] - 1;
    assign m_slice = m_chan == grp_t[m_layer] - 1 && kind_t[m_layer] != K_PW2DW
                     && m_layer != NUM_LAYERS - 1;

    always @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            m_layer  <= 0;
            m_col    <= 0;
            m_row    <= 0;
            m_chan   <= 0;
            m_passes <= 0;
            for (int i = 0; i < 3; i++) begin
                exp_vld[i]   <= 1'b0;
                exp_ins[i]   <= '0;
                exp_slice[i] <= 1'b0;
                exp_fin[i]   <= 1'b0;
            end
        end else begin
            for (int i = 1; i < 3; i++) begin
                exp_vld[i]   <= exp_vld[i-1];
                exp_ins[i]   <= exp_ins[i-1];
                exp_slice[i] <= exp_slice[i-1];
                exp_fin[i]   <= exp_fin[i-1];
            end
            exp_vld[0]   <= data_in_vld_i;
            exp_ins[0]   <= '0;
            exp_slice[0] <= data_in_vld_i & m_slice;
            exp_fin[0]   <= data_in_vld_i & m_end & (m_layer == NUM_LAYERS - 1);
            if (data_in_vld_i) begin
                exp_ins[0] <= {m_end, data_in_i, ref_addr(m_layer, m_col, m_row, m_chan),
                               BL_W'(kind_t[m_layer] == K_PW2DW ? 32 : 1)};
                if (m_col != pic_t[m_layer] - 1) begin
                    m_col <= m_col + 1;
                end else begin
                    m_col <= 0;
                    if (m_row != pic_t[m_layer] - 1) begin
                        m_row <= m_row + 1;
                    end else begin
                        m_row <= 0;
                        if (m_chan != grp_t[m_layer] - 1) begin
                            m_chan <= m_chan + 1;
                        end else begin
                            m_chan  <= 0;
                            m_layer <= (m_layer == NUM_LAYERS - 1) ? 0 : m_layer + 1;
                            if (m_layer == NUM_LAYERS - 1) begin
                                m_passes <= m_passes + 1;
                            end
                        end
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    a_idle: assert property (@(posedge clk_calc) disable iff (!rst_n)
        !exp_vld[2] |-> !ddr_wr_ins_vld_o && ddr_wr_ins_o == '0 && !last_slice_vld_o
            && !net_all_finish_o)
        else report_mismatch(0, "outputs", 0, $sampled({ddr_wr_ins_vld_o, last_slice_vld_o,
                             net_all_finish_o, ddr_wr_ins_o}));
    a_vld: assert property (@(posedge clk_calc) disable iff (!rst_n)
        ddr_wr_ins_vld_o == exp_vld[2])
        else report_mismatch(1, "valid", $sampled(exp_vld[2]), $sampled(ddr_wr_ins_vld_o));
    a_addr: assert property (@(posedge clk_calc) disable iff (!rst_n)
        exp_vld[2] |-> ddr_wr_ins_o[BL_W +: ADDR_W] == exp_ins[2][BL_W +: ADDR_W])
        else report_mismatch(1, "address", $sampled(exp_ins[2][BL_W +: ADDR_W]),
                             $sampled(ddr_wr_ins_o[BL_W +: ADDR_W]));
    a_data: assert property (@(posedge clk_calc) disable iff (!rst_n)
        exp_vld[2] |-> ddr_wr_ins_o[BL_W+ADDR_W +: DATA_W] == exp_ins[2][BL_W+ADDR_W +: DATA_W])
        else report_mismatch(1, "data", $sampled(exp_ins[2][BL_W+ADDR_W +: DATA_W]),
                             $sampled(ddr_wr_ins_o[BL_W+ADDR_W +: DATA_W]));
    a_burst: assert property (@(posedge clk_calc) disable iff (!rst_n)
        exp_vld[2] |-> ddr_wr_ins_o[BL_W-1:0] == exp_ins[2][BL_W-1:0])
        else report_mismatch(2, "burst", $sampled(exp_ins[2][BL_W-1:0]),
                             $sampled(ddr_wr_ins_o[BL_W-1:0]));
    a_lend: assert property (@(posedge clk_calc) disable iff (!rst_n)
        exp_vld[2] |-> ddr_wr_ins_o[INS_W-1] == exp_ins[2][INS_W-1])
        else report_mismatch(2, "layer_end", $sampled(exp_ins[2][INS_W-1]),
                             $sampled(ddr_wr_ins_o[INS_W-1]));
    a_slice: assert property (@(posedge clk_calc) disable iff (!rst_n)
        last_slice_vld_o == exp_slice[2])
        else report_mismatch(3, "pulse", $sampled(exp_slice[2]), $sampled(last_slice_vld_o));
    a_fin: assert property (@(posedge clk_calc) disable iff (!rst_n)
        net_all_finish_o == exp_fin[2])
        else report_mismatch(4, "pulse", $sampled(exp_fin[2]), $sampled(net_all_finish_o));

    // how often each check saw something worth checking
    always @(posedge clk_calc) begin
        if (rst_n) begin
            if (!exp_vld[2]) begin
                n_idle <= n_idle + 1;
            end else begin
                n_ins  <= n_ins + 1;
                n_bl32 <= n_bl32 + (exp_ins[2][BL_W-1:0] == BL_W'(32));
                n_bl1  <= n_bl1 + (exp_ins[2][BL_W-1:0] == BL_W'(1));
                n_lend <= n_lend + exp_ins[2][INS_W-1];
            end
            n_slice   <= n_slice + exp_slice[2];
            n_fin_exp <= n_fin_exp + exp_fin[2];
            n_fin_obs <= n_fin_obs + net_all_finish_o;
        end
    end

    initial begin
        void'($urandom(32'hbf19d1dc));
        data_in_vld_i <= 1'b0;
        data_in_i     <= '0;
        timed_out     = 1'b0;
        cycles        = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk_calc);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        // a few idle cycles first, then two passes and a bit of a third
        repeat (4) @(posedge clk_calc);
        cycles = 0;
        extra  = 0;
        while (!timed_out && extra < 8) begin
            @(posedge clk_calc);
            cycles++;
            if (cycles > STIM_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: two network passes not done in %0d cycles", STIM_LIMIT);
            end else if (($urandom % 100) < 30) begin
                data_in_vld_i <= 1'b0;
            end else begin
                data_in_vld_i <= 1'b1;
                data_in_i     <= random_beat();
                if (m_passes >= 2) begin
                    extra++;
                end
            end
        end
        @(posedge clk_calc);
        data_in_vld_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk_calc);
            cycles++;
        end while ((exp_vld[0] || exp_vld[1] || exp_vld[2]) && cycles < 10);
        if (cycles >= 10) begin
            timed_out = 1'b1;
            $display("timeout: instructions still in flight after the last beat");
        end
        @(posedge clk_calc);

        if (n_idle == 0) not_reached(0, "no idle cycle after reset");
        if (n_ins < 614) not_reached(1, "fewer beats than two passes");
        if (n_bl32 == 0 || n_bl1 == 0 || n_lend < 12) not_reached(2, "missing burst kinds");
        if (n_slice == 0) not_reached(3, "no last-slice beat");
        if (n_fin_exp != 2) not_reached(4, "model did not finish two passes");
        if (n_fin_obs != 2) report_mismatch(4, "pulse count", 2, n_fin_obs);

        total_err = 0;
        n_ok      = 0;
        for (int t = 0; t < 5; t++) begin
            $display("test %-16s %s (%0d errors)", names[t], err[t] == 0 ? "ok" : "bad", err[t]);
            total_err += err[t];
            n_ok      += (err[t] == 0);
        end
        $display("tests run 5, ok %0d, with errors %0d", n_ok, 5 - n_ok);
        if (timed_out || total_err != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime PERIOD_NS  = 10.0,
    parameter int      RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o <= 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // release on a rising edge
    initial begin
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== src/addr_map_top.sv ====
`timescale 1ns/1ps

module addr_map_top #(
    parameter int LANE_W = 32,
    parameter int LANES  = 16
) (
    input  logic                        clk_calc,
    input  logic                        rst_n,
    input  logic [LANE_W*LANES-1:0]     data_in_i,
    input  logic                        data_in_vld_i,
    output logic                        ddr_wr_ins_vld_o,
    output logic [1+LANE_W*LANES+addr_map_pkg::ADDR_W+addr_map_pkg::BL_W-1:0] ddr_wr_ins_o,
    output logic                        last_slice_vld_o,
    output logic                        net_all_finish_o
);

    import addr_map_pkg::*;

    logic [LAYER_W-1:0]      layer_idx;
    logic [CNT_W-1:0]        col;
    logic [CNT_W-1:0]        row;
    logic [CNT_W-1:0]        chan;
    logic                    layer_end;
    logic                    last_slice;
    logic                    net_end;
    logic [ADDR_W-1:0]       addr;
    ctrl_beat_t              ctrl_in;
    ctrl_beat_t              ctrl_dly;
    logic [LANE_W*LANES-1:0] data_dly;

    layer_sequencer u_seq (
        .clk_calc    (clk_calc),
        .rst_n       (rst_n),
        .layer_end_i (layer_end),
        .layer_idx_o (layer_idx),
        .net_end_o   (net_end)
    );

    reorder_counter u_cnt (
        .clk_calc     (clk_calc),
        .rst_n        (rst_n),
        .beat_i       (data_in_vld_i),
        .layer_idx_i  (layer_idx),
        .col_o        (col),
        .row_o        (row),
        .chan_o       (chan),
        .layer_end_o  (layer_end),
        .last_slice_o (last_slice)
    );

    reorder_addr_gen u_addr (
        .clk_calc    (clk_calc),
        .rst_n       (rst_n),
        .layer_idx_i (layer_idx),
        .col_i       (col),
        .row_i       (row),
        .chan_i      (chan),
        .addr_o      (addr)
    );

    // beat control travels alongside the address pipeline
    assign ctrl_in = '{vld: data_in_vld_i, kind: kind_of(layer_idx), layer_end: layer_end,
                       last_slice: last_slice, net_end: net_end};

    beat_delay #(.payload_t(ctrl_beat_t), .DEPTH(2)) u_ctrl_dly (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .in_i     (ctrl_in),
        .out_o    (ctrl_dly)
    );

    beat_delay #(.payload_t(logic [LANE_W*LANES-1:0]), .DEPTH(2)) u_data_dly (
        .clk_calc (clk_calc),
        .rst_n    (rst_n),
        .in_i     (data_in_i),
        .out_o    (data_dly)
    );

    ddr_ins_packer #(.LANE_W(LANE_W), .LANES(LANES)) u_pack (
        .clk_calc         (clk_calc),
        .rst_n            (rst_n),
        .ctrl_i           (ctrl_dly),
        .data_i           (data_dly),
        .addr_i           (addr),
        .ddr_wr_ins_vld_o (ddr_wr_ins_vld_o),
        .ddr_wr_ins_o     (ddr_wr_ins_o),
        .last_slice_vld_o (last_slice_vld_o),
        .net_all_finish_o (net_all_finish_o)
    );

endmodule

// ==== src/ddr_ins_packer.sv ====
`timescale 1ns/1ps

module ddr_ins_packer #(
    parameter int LANE_W = 32,
    parameter int LANES  = 16
) (
    input  logic                             clk_calc,
    input  logic                             rst_n,
    input  addr_map_pkg::ctrl_beat_t         ctrl_i,
    input  logic [LANE_W*LANES-1:0]          data_i,
    input  logic [addr_map_pkg::ADDR_W-1:0]  addr_i,
    output logic                             ddr_wr_ins_vld_o,
    output logic [1+LANE_W*LANES+addr_map_pkg::ADDR_W+addr_map_pkg::BL_W-1:0] ddr_wr_ins_o,
    output logic                             last_slice_vld_o,
    output logic                             net_all_finish_o
);

    import addr_map_pkg::*;

    logic [BL_W-1:0] burst_len;

    // whole-plane writes for pw2dw, single beats otherwise
    assign burst_len = (ctrl_i.kind == PW2DW) ? BL_W'(BURST_PW2DW) : BL_W'(1);

    // ----------------------------------------------------------------------
    // instruction {layer_end, data, addr, burst}
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            ddr_wr_ins_vld_o <= 1'b0;
            ddr_wr_ins_o     <= '0;
            last_slice_vld_o <= 1'b0;
            net_all_finish_o <= 1'b0;
        end else if (ctrl_i.vld) begin
            ddr_wr_ins_vld_o <= 1'b1;
            ddr_wr_ins_o     <= {ctrl_i.layer_end, data_i, addr_i, burst_len};
            last_slice_vld_o <= ctrl_i.last_slice;
            net_all_finish_o <= ctrl_i.net_end;
        end else begin
            ddr_wr_ins_vld_o <= 1'b0;
            ddr_wr_ins_o     <= '0;
            last_slice_vld_o <= 1'b0;
            net_all_finish_o <= 1'b0;
        end
    end

endmodule

// ==== src/beat_delay.sv ====
`timescale 1ns/1ps

module beat_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk_calc,
    input  logic     rst_n,
    input  payload_t in_i,
    output payload_t out_o
);

    payload_t stage_q [DEPTH];

    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= in_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign out_o = stage_q[DEPTH-1];

endmodule

// ==== src/reorder_addr_gen.sv ====
`timescale 1ns/1ps

module reorder_addr_gen (
    input  logic                              clk_calc,
    input  logic                              rst_n,
    input  logic [addr_map_pkg::LAYER_W-1:0]  layer_idx_i,
    input  logic [addr_map_pkg::CNT_W-1:0]    col_i,
    input  logic [addr_map_pkg::CNT_W-1:0]    row_i,
    input  logic [addr_map_pkg::CNT_W-1:0]    chan_i,
    output logic [addr_map_pkg::ADDR_W-1:0]   addr_o
);

    import addr_map_pkg::*;

    logic [ADDR_W-1:0] pic_w;
    logic [ADDR_W-1:0] grp_w;
    logic [ADDR_W-1:0] col_w;
    logic [ADDR_W-1:0] row_w;
    logic [ADDR_W-1:0] chan_w;
    logic [ADDR_W-1:0] pix_w;

    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] term_a_q;
    logic [ADDR_W-1:0] term_b_q;
    logic [ADDR_W-1:0] addr_q;

    assign pic_w  = ADDR_W'(pic_of(layer_idx_i));
    assign grp_w  = ADDR_W'(groups_of(layer_idx_i));
    assign col_w  = ADDR_W'(col_i);
    assign row_w  = ADDR_W'(row_i);
    assign chan_w = ADDR_W'(chan_i);

    // pixel offset inside one picture
    assign pix_w = row_w * pic_w + col_w;

    // ----------------------------------------------------------------------
    // stage 1 registers the layout dependent terms
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            base_q   <= '0;
            term_a_q <= '0;
            term_b_q <= '0;
        end else begin
            base_q <= base_of(layer_idx_i);
            case (kind_of(layer_idx_i))
                PW2DW: begin
                    // channel-group planar
                    term_a_q <= chan_w * pic_w * pic_w;
                    term_b_q <= pix_w;
                end
                PW2PW: begin
                    // channel groups interleaved per pixel
                    term_a_q <= pix_w * grp_w;
                    term_b_q <= chan_w;
                end
                default: begin
                    term_a_q <= '0;
                    term_b_q <= chan_w;
                end
            endcase
        end
    end

    // stage 2 registers the final sum
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else begin
            addr_q <= base_q + term_a_q + term_b_q;
        end
    end

    assign addr_o = addr_q;

endmodule

// ==== src/reorder_counter.sv ====
`timescale 1ns/1ps

module reorder_counter (
    input  logic                              clk_calc,
    input  logic                              rst_n,
    input  logic                              beat_i,
    input  logic [addr_map_pkg::LAYER_W-1:0]  layer_idx_i,
    output logic [addr_map_pkg::CNT_W-1:0]    col_o,
    output logic [addr_map_pkg::CNT_W-1:0]    row_o,
    output logic [addr_map_pkg::CNT_W-1:0]    chan_o,
    output logic                              layer_end_o,
    output logic                              last_slice_o
);

    import addr_map_pkg::*;

    logic [CNT_W-1:0] col_q;
    logic [CNT_W-1:0] row_q;
    logic [CNT_W-1:0] chan_q;
    logic [CNT_W-1:0] pic_last;
    logic [CNT_W-1:0] grp_last;
    logic             col_end;
    logic             row_end;
    logic             chan_end;
    logic             slice_kind;

    assign pic_last = pic_of(layer_idx_i) - 1'b1;
    assign grp_last = groups_of(layer_idx_i) - 1'b1;

    assign col_end  = col_q == pic_last;
    assign row_end  = row_q == pic_last;
    assign chan_end = chan_q == grp_last;

    // ----------------------------------------------------------------------
    // column fastest, then row, then channel group
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            col_q  <= '0;
            row_q  <= '0;
            chan_q <= '0;
        end else if (beat_i) begin
            col_q <= col_end ? '0 : col_q + 1'b1;
            if (col_end) begin
                row_q <= row_end ? '0 : row_q + 1'b1;
            end
            if (col_end && row_end) begin
                chan_q <= chan_end ? '0 : chan_q + 1'b1;
            end
        end
    end

    assign col_o  = col_q;
    assign row_o  = row_q;
    assign chan_o = chan_q;

    // flags describe the beat being accepted this cycle
    assign layer_end_o = beat_i & col_end & row_end & chan_end;

    // pw layers only, and never on the final layer
    assign slice_kind   = (kind_of(layer_idx_i) != PW2DW) & ~is_last_layer(layer_idx_i);
    assign last_slice_o = beat_i & chan_end & slice_kind;

endmodule

// ==== src/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer (
    input  logic                              clk_calc,
    input  logic                              rst_n,
    input  logic                              layer_end_i,
    output logic [addr_map_pkg::LAYER_W-1:0]  layer_idx_o,
    output logic                              net_end_o
);

    import addr_map_pkg::*;

    logic [LAYER_W-1:0] layer_q;
    logic [LAYER_W-1:0] layer_d;
    logic               last_layer;

    assign last_layer = is_last_layer(layer_q);

    // step to the next table entry, back to 0 after the last one
    always_comb begin
        layer_d = layer_q;
        if (layer_end_i) begin
            if (last_layer) begin
                layer_d = '0;
            end else begin
                layer_d = layer_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_calc or negedge rst_n) begin
        if (!rst_n) begin
            layer_q <= '0;
        end else begin
            layer_q <= layer_d;
        end
    end

    assign layer_idx_o = layer_q;

    // final beat of the whole network pass
    assign net_end_o = layer_end_i & last_layer;

endmodule

// ==== src/addr_map_pkg.sv ====
package addr_map_pkg;

    typedef enum logic [1:0] {
        PW2DW  = 2'd0,
        PW2PW  = 2'd2,
        AVG2PW = 2'd3
    } layer_kind_e;

    localparam int NUM_LAYERS  = 6;
    localparam int ADDR_W      = 26;
    localparam int BL_W        = 7;
    localparam int CNT_W       = 8;
    localparam int LAYER_W     = 3;
    localparam int BURST_PW2DW = 32;

    // ---------------------------------------------------------------------
    // layer table
    // ---------------------------------------------------------------------
    localparam layer_kind_e layer_kind_tab [NUM_LAYERS] =
        '{PW2DW, PW2PW, PW2DW, PW2PW, AVG2PW, PW2PW};

    localparam logic [CNT_W-1:0] pic_size_tab [NUM_LAYERS] = '{8, 8, 4, 4, 1, 1};

    // in units of 16 output channels
    localparam logic [CNT_W-1:0] chan_groups_tab [NUM_LAYERS] = '{2, 2, 1, 2, 2, 1};

    localparam logic [ADDR_W-1:0] base_addr_tab [NUM_LAYERS] =
        '{1000000, 1000128, 1000256, 1000272, 1000304, 1000306};

    typedef struct packed {
        logic        vld;
        layer_kind_e kind;
        logic        layer_end;
        logic        last_slice;
        logic        net_end;
    } ctrl_beat_t;

    function automatic layer_kind_e kind_of(input logic [LAYER_W-1:0] idx);
        return layer_kind_tab[idx];
    endfunction

    function automatic logic [CNT_W-1:0] pic_of(input logic [LAYER_W-1:0] idx);
        return pic_size_tab[idx];
    endfunction

    function automatic logic [CNT_W-1:0] groups_of(input logic [LAYER_W-1:0] idx);
        return chan_groups_tab[idx];
    endfunction

    function automatic logic [ADDR_W-1:0] base_of(input logic [LAYER_W-1:0] idx);
        return base_addr_tab[idx];
    endfunction

    function automatic logic is_last_layer(input logic [LAYER_W-1:0] idx);
        return idx == LAYER_W'(NUM_LAYERS - 1);
    endfunction

endpackage
